// File: periph_top.f
+incdir+.
periph_pkg.sv
byte_bus_if.sv
bus_slave_ctrl.sv
wb_data_resize.sv
gpio_port.sv
boot_rom.sv
periph_top.sv
periph_top_props.sv
tb_periph_top.sv

// File: tb_periph_top.sv
`timescale 1ns/10ps
`include "periph_cfg.svh"

module tb_periph_top;

	localparam periph_pkg::bus_adr_t GPIO_BASE = {16'h0, `REGION_GPIO, 12'h0};

	logic wb_clk_i;
	logic reset_i;
	logic cyc_i;
	logic stb_i;
	logic we_i;
	periph_pkg::bus_adr_t adr_i;
	periph_pkg::bus_dat_t dat_i;
	periph_pkg::bus_sel_t sel_i;
	periph_pkg::byte_t gpio_i;
	logic ack_o;
	periph_pkg::bus_dat_t rdat_o;
	periph_pkg::byte_t gpio_o;
	periph_pkg::byte_t gpio_oe_o;

	// Mirrored GPIO registers and pins
	periph_pkg::byte_t out_m;
	periph_pkg::byte_t dir_m;
	periph_pkg::byte_t pin_m;
	periph_pkg::bus_dat_t exp_dat;
	logic [31:0] lfsr = 32'h4eb7;
	int checks = 0;
	int errors = 0;
	int err_base = 0;

	periph_top dut (.*);

	initial begin
		wb_clk_i = 1'b0;
		forever #4 wb_clk_i = ~wb_clk_i;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int lane_of(input periph_pkg::bus_sel_t sel);
		for (int i = 0; i < 4; i++)
			if (sel[i])
				return i;
		return 0;
	endfunction

	function automatic periph_pkg::bus_dat_t expected_read(input periph_pkg::bus_adr_t adr,
			input periph_pkg::bus_sel_t sel, input logic we);
		periph_pkg::byte_t b;
		if (we || adr[15:12] > `REGION_GPIO)
			return '0;
		if (adr[15:12] == `REGION_ROM)
			return {`ROM_TAG, 10'd0, adr[7:2]};
		// Odd lanes reach the direction register
		if (lane_of(sel) % 2 == 1)
			return {4{dir_m}};
		// Output pins read their drive value, inputs the pin
		for (int i = 0; i < 8; i++)
			b[i] = dir_m[i] ? out_m[i] : pin_m[i];
		return {4{b}};
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expv);
		checks++;
		assert (got === expv) else begin
			errors++;
			$display("[FAIL] %s expected %h got %h", name, expv, got);
		end
	endtask

	task automatic bus_access(input periph_pkg::bus_adr_t adr, input periph_pkg::bus_dat_t dat,
			input periph_pkg::bus_sel_t sel, input logic we);
		int n;
		exp_dat = expected_read(adr, sel, we);
		@(posedge wb_clk_i);
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		we_i  <= we;
		adr_i <= adr;
		dat_i <= dat;
		sel_i <= sel;
		n = 0;
		do begin
			@(negedge wb_clk_i);
			n++;
		end while (!ack_o && n < 20);
		// Drive edge, accepting edge, then two more
		assert (ack_o && n == 3) else begin
			errors++;
			$display("no acknowledge two cycles after acceptance at address %h", adr);
		end
		@(posedge wb_clk_i);
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		we_i  <= 1'b0;
		if (we && adr[15:12] == `REGION_GPIO) begin
			if (lane_of(sel) % 2 == 1)
				dir_m = dat[lane_of(sel)*8 +: 8];
			else
				out_m = dat[lane_of(sel)*8 +: 8];
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %-20s %0d errors", name, errors - err_base);
		err_base = errors;
	endtask

	// Read data compare on every acknowledge
	always @(negedge wb_clk_i) begin
		if (!reset_i && ack_o)
			check_val("rdat_o", rdat_o, exp_dat);
	end

	initial begin
		periph_pkg::bus_adr_t a;
		periph_pkg::bus_sel_t s;
		periph_pkg::byte_t pins;
		{cyc_i, stb_i, we_i, adr_i, dat_i, sel_i, gpio_i} = '0;
		{out_m, dir_m, pin_m, exp_dat} = '0;
		reset_i = 1'b1;
		repeat (5) @(posedge wb_clk_i);
		reset_i <= 1'b0;
		@(negedge wb_clk_i);
		check_val("ack_o", 32'(ack_o), 0);
		check_val("gpio_o", 32'(gpio_o), 0);
		check_val("gpio_oe_o", 32'(gpio_oe_o), 0);
		finish_test("reset values");

		for (int i = 0; i < 16; i++) begin
			a = 32'(rand_bits(6)) << 2;
			bus_access(a, '0, 4'hf, 1'b0);
		end
		bus_access(32'h24, rand_bits(32), 4'hf, 1'b1);
		bus_access(32'h24, '0, 4'hf, 1'b0);
		finish_test("boot ROM");

		// Random upper selects above the wanted lane
		for (int l = 0; l < 4; l++) begin
			s = (4'(rand_bits(4)) | (4'b1 << l)) & ~((4'b1 << l) - 4'b1);
			bus_access(GPIO_BASE, rand_bits(32), s, 1'b1);
			check_val("gpio_o", 32'(gpio_o), 32'(out_m));
			check_val("gpio_oe_o", 32'(gpio_oe_o), 32'(dir_m));
		end
		for (int l = 0; l < 4; l++)
			bus_access(GPIO_BASE, '0, 4'b1 << l, 1'b0);
		finish_test("GPIO lanes");

		for (int k = 0; k < 6; k++) begin
			bus_access(GPIO_BASE, rand_bits(32), 4'b0010, 1'b1);
			bus_access(GPIO_BASE, rand_bits(32), 4'b0001, 1'b1);
			pins = 8'(rand_bits(8));
			@(posedge wb_clk_i);
			gpio_i <= pins;
			// Past the input synchronizer
			repeat (3) @(posedge wb_clk_i);
			pin_m = pins;
			bus_access(GPIO_BASE, '0, 4'b0001, 1'b0);
		end
		finish_test("GPIO pins");

		for (int k = 0; k < 4; k++) begin
			a = {16'h0, 4'(2 + rand_bits(4) % 14), 12'(rand_bits(12))};
			bus_access(a, '0, 4'hf, 1'b0);
			bus_access(a, rand_bits(32), 4'hf, 1'b1);
		end
		finish_test("unmapped region");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: periph_top_props.sv
`timescale 1ns/10ps

module periph_top_props (
	input logic                 wb_clk_i,
	input logic                 reset_i,
	input logic                 cyc_i,
	input logic                 stb_i,
	input logic                 ack_i,
	input periph_pkg::bus_dat_t rdat_i
);

	logic wait_q;
	logic accept;

	// Slave is idle when neither waiting nor acknowledging
	assign accept = cyc_i && stb_i && !wait_q && !ack_i;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			wait_q <= 1'b0;
		else
			wait_q <= accept;
	end

	a_ack_single: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		ack_i |=> !ack_i) else $error("ack_o held for more than one cycle");

	a_ack_latency: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		accept |=> !ack_i ##1 ack_i) else $error("ack_o not two cycles after acceptance");

	a_rdat_idle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		!ack_i |-> rdat_i == '0) else $error("rdat_o nonzero without ack_o");

endmodule

bind periph_top periph_top_props u_props (
	.wb_clk_i (wb_clk_i),
	.reset_i  (reset_i),
	.cyc_i    (cyc_i),
	.stb_i    (stb_i),
	.ack_i    (ack_o),
	.rdat_i   (rdat_o)
);

// File: periph_top.sv
`timescale 1ns/10ps
`include "periph_cfg.svh"

module periph_top (
	input  logic                 wb_clk_i,
	input  logic                 reset_i,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  periph_pkg::bus_adr_t adr_i,
	input  periph_pkg::bus_dat_t dat_i,
	input  periph_pkg::bus_sel_t sel_i,
	input  periph_pkg::byte_t    gpio_i,
	output logic                 ack_o,
	output periph_pkg::bus_dat_t rdat_o,
	output periph_pkg::byte_t    gpio_o,
	output periph_pkg::byte_t    gpio_oe_o
);

	logic rom_en;
	logic gpio_stb;
	periph_pkg::bus_dat_t rom_dat;
	periph_pkg::bus_dat_t gpio_rdat;

	byte_bus_if gpio_nb ();

	////////////////////////////////////////////////////////////
	// Bus control
	////////////////////////////////////////////////////////////

	bus_slave_ctrl u_ctrl (
		.wb_clk_i    (wb_clk_i),
		.reset_i     (reset_i),
		.cyc_i       (cyc_i),
		.stb_i       (stb_i),
		.we_i        (we_i),
		.adr_i       (adr_i),
		.rom_dat_i   (rom_dat),
		.gpio_rdat_i (gpio_rdat),
		.rom_en_o    (rom_en),
		.gpio_stb_o  (gpio_stb),
		.ack_o       (ack_o),
		.rdat_o      (rdat_o)
	);

	////////////////////////////////////////////////////////////
	// Boot ROM
	////////////////////////////////////////////////////////////

	boot_rom u_rom (
		.wb_clk_i (wb_clk_i),
		.rom_en_i (rom_en),
		.adr_i    (adr_i[`ROM_AW+1:2]),
		.dat_o    (rom_dat)
	);

	////////////////////////////////////////////////////////////
	// GPIO behind the 32 to 8 resizer
	////////////////////////////////////////////////////////////

	wb_data_resize u_resize (
		.adr_i  (adr_i),
		.dat_i  (dat_i),
		.sel_i  (sel_i),
		.we_i   (we_i),
		.stb_i  (gpio_stb),
		.rdat_o (gpio_rdat),
		.nb     (gpio_nb.host)
	);

	gpio_port u_gpio (
		.wb_clk_i  (wb_clk_i),
		.reset_i   (reset_i),
		.nb        (gpio_nb.target),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.gpio_oe_o (gpio_oe_o)
	);

endmodule

// File: boot_rom.sv
`timescale 1ns/10ps
`include "periph_cfg.svh"

module boot_rom (
	input  logic                 wb_clk_i,
	input  logic                 rom_en_i,
	input  periph_pkg::rom_adr_t adr_i,
	output periph_pkg::bus_dat_t dat_o
);

	localparam int DEPTH = 1 << `ROM_AW;

	periph_pkg::bus_dat_t rom_tab [DEPTH];

	////////////////////////////////////////////////////////////
	// Word table
	////////////////////////////////////////////////////////////

	// Tag on top, word index below
	genvar g;
	generate
		for (g = 0; g < DEPTH; g++) begin : g_word
			assign rom_tab[g] = {`ROM_TAG, 16'(g)};
		end
	endgenerate

	////////////////////////////////////////////////////////////
	// Registered read
	////////////////////////////////////////////////////////////

	// Loaded while enabled, held otherwise
	always_ff @(posedge wb_clk_i) begin
		if (rom_en_i)
			dat_o <= rom_tab[adr_i];
	end

endmodule

// File: gpio_port.sv
`timescale 1ns/10ps

module gpio_port (
	input  logic              wb_clk_i,
	input  logic              reset_i,
	byte_bus_if.target        nb,
	input  periph_pkg::byte_t gpio_i,
	output periph_pkg::byte_t gpio_o,
	output periph_pkg::byte_t gpio_oe_o
);

	periph_pkg::byte_t out_q;
	periph_pkg::byte_t dir_q;
	periph_pkg::byte_t pin_meta_q;
	periph_pkg::byte_t pin_q;
	periph_pkg::byte_t pin_val;

	////////////////////////////////////////////////////////////
	// Register writes
	////////////////////////////////////////////////////////////

	// Reg 0 is output data, reg 1 is direction (1 = drive)
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			out_q <= '0;
			dir_q <= '0;
		end else if (nb.stb && nb.we) begin
			if (nb.adr)
				dir_q <= nb.wdat;
			else
				out_q <= nb.wdat;
		end
	end

	// Two flops on the pad inputs
	always_ff @(posedge wb_clk_i) begin
		pin_meta_q <= gpio_i;
		pin_q      <= pin_meta_q;
	end

	////////////////////////////////////////////////////////////
	// Read back
	////////////////////////////////////////////////////////////

	// An output pin reads its own drive value
	assign pin_val = (dir_q & out_q) | (~dir_q & pin_q);

	assign nb.rdat = nb.adr ? dir_q : pin_val;

	// Tristate buffers live in the pads
	assign gpio_o    = out_q;
	assign gpio_oe_o = dir_q;

endmodule

// File: wb_data_resize.sv
`timescale 1ns/10ps
`include "periph_cfg.svh"

module wb_data_resize (
	input  periph_pkg::bus_adr_t adr_i,
	input  periph_pkg::bus_dat_t dat_i,
	input  periph_pkg::bus_sel_t sel_i,
	input  logic                 we_i,
	input  logic                 stb_i,
	output periph_pkg::bus_dat_t rdat_o,
	byte_bus_if.host             nb
);

	localparam int LANES = `PERIPH_DAT_W / `GPIO_W;

	logic [1:0] lane;
	periph_pkg::bus_adr_t nb_byte_adr;

	// Lowest active byte select wins, lane 0 when none is set
	always_comb begin
		lane = '0;
		for (int i = LANES - 1; i >= 0; i--) begin
			if (sel_i[i])
				lane = 2'(i);
		end
	end

	// Byte address seen from the narrow side
	assign nb_byte_adr = {adr_i[`PERIPH_ADR_W-1:2], lane};

	// GPIO decodes only the low bit of it
	assign nb.adr  = nb_byte_adr[0];
	assign nb.wdat = dat_i[lane*`GPIO_W +: `GPIO_W];
	assign nb.we   = we_i;
	assign nb.stb  = stb_i;

	// Returned byte shows up on every lane
	assign rdat_o = {LANES{nb.rdat}};

endmodule

// File: bus_slave_ctrl.sv
`timescale 1ns/10ps
`include "periph_cfg.svh"

module bus_slave_ctrl (
	input  logic                 wb_clk_i,
	input  logic                 reset_i,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  periph_pkg::bus_adr_t adr_i,
	input  periph_pkg::bus_dat_t rom_dat_i,
	input  periph_pkg::bus_dat_t gpio_rdat_i,
	output logic                 rom_en_o,
	output logic                 gpio_stb_o,
	output logic                 ack_o,
	output periph_pkg::bus_dat_t rdat_o
);

	periph_pkg::ctrl_state_t state_q;
	periph_pkg::ctrl_state_t state_d;
	logic sel_rom_q;
	logic sel_gpio_q;
	logic req;
	logic [3:0] region;

	assign req = cyc_i & stb_i;
	assign region = adr_i[15:12];

	////////////////////////////////////////////////////////////
	// Access sequencing
	////////////////////////////////////////////////////////////

	// IDLE -> WAIT -> ACK, stb_i is not looked at in ACK
	always_comb begin
		state_d = state_q;
		case (state_q)
			periph_pkg::IDLE: begin
				if (req)
					state_d = periph_pkg::WAIT;
			end
			periph_pkg::WAIT: state_d = periph_pkg::ACK;
			default: state_d = periph_pkg::IDLE;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			state_q    <= periph_pkg::IDLE;
			sel_rom_q  <= 1'b0;
			sel_gpio_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Region decoded once, on the accepting edge
			if (state_q == periph_pkg::IDLE && req) begin
				sel_rom_q  <= (region == `REGION_ROM);
				sel_gpio_q <= (region == `REGION_GPIO);
			end
		end
	end

	assign ack_o = (state_q == periph_pkg::ACK);

	// Target strobes, both only in WAIT
	assign rom_en_o   = (state_q == periph_pkg::WAIT) && sel_rom_q && !we_i;
	assign gpio_stb_o = (state_q == periph_pkg::WAIT) && sel_gpio_q;

	////////////////////////////////////////////////////////////
	// Read data return
	////////////////////////////////////////////////////////////

	// Zero outside ACK, on writes and for unmapped regions
	always_comb begin
		rdat_o = '0;
		if (ack_o && !we_i) begin
			if (sel_rom_q)
				rdat_o = rom_dat_i;
			else if (sel_gpio_q)
				rdat_o = gpio_rdat_i;
		end
	end

endmodule

// File: byte_bus_if.sv
`timescale 1ns/10ps

// Narrow register bus between the resizer and the GPIO block
interface byte_bus_if;

	// Register select, 0 = output data, 1 = direction
	logic adr;

	periph_pkg::byte_t wdat;
	periph_pkg::byte_t rdat;
	logic we;
	logic stb;

	// Resizer side
	modport host (
		output adr,
		output wdat,
		output we,
		output stb,
		input  rdat
	);

	// GPIO side, read data is combinational from adr
	modport target (
		input  adr,
		input  wdat,
		input  we,
		input  stb,
		output rdat
	);

endinterface

// File: periph_pkg.sv
`include "periph_cfg.svh"

package periph_pkg;

	////////////////////////////////////////////////////////////
	// Bus vectors
	////////////////////////////////////////////////////////////

	// Byte address on the wide bus
	typedef logic [`PERIPH_ADR_W-1:0] bus_adr_t;

	typedef logic [`PERIPH_DAT_W-1:0] bus_dat_t;

	// One select per byte lane
	typedef logic [`PERIPH_DAT_W/8-1:0] bus_sel_t;

	// Narrow data, also one bit per pin
	typedef logic [`GPIO_W-1:0] byte_t;

	// Word index into the boot ROM
	typedef logic [`ROM_AW-1:0] rom_adr_t;

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		ACK
	} ctrl_state_t;

endpackage

// File: periph_cfg.svh
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// 32-bit peripheral bus
`define PERIPH_ADR_W 32
`define PERIPH_DAT_W 32

// Pin count, also the width of the narrow register bus
`define GPIO_W 8

// Boot ROM depth in words (64)
`define ROM_AW 6

// Upper half of every ROM word
`define ROM_TAG 16'hb007

// Region numbers, taken from address bits 15:12
`define REGION_ROM 4'd0
`define REGION_GPIO 4'd1

`endif
